// File: vlog.f
clic_pkg.sv
clic_src_arbiter.sv
clic_hart_ctrl.sv
clic_trap_csr.sv
clic_subsys_top.sv
clic_tb_clk.sv
clic_tb_sva.sv
clic_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the CLIC testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wall -Wno-fatal \
  --top-module clic_tb -f vlog.f -o clic_sim
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

./obj_dir/clic_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
exit 0

// File: clic_tb.sv
// ----------------------------------------
// CLIC subsystem testbench: CSR reference
// model, directed and random irq stimulus
// ----------------------------------------

`timescale 1ns/1ps

module clic_tb;
  import clic_pkg::*;

  logic clk, rst_n, cfg_we, cfg_en, cfg_v, csr_we, mret, trap, v, kill_ack;
  logic [7:0] src, cfg_level, mil;
  logic [2:0] cfg_id;
  logic [5:0] cfg_vsid;
  logic [31:0] csr_wdata, trap_cause;
  priv_lvl_e cfg_priv, priv;
  csr_addr_e csr_addr;

  // Reference state
  priv_lvl_e r_priv, s_priv, c_priv [8];
  logic r_v, s_v, r_sie, r_vsie, r_sgeie, c_v [8];
  logic [7:0] r_mth, r_sth, r_vsth, r_mil, r_sil, r_vsil, s_lvl, c_lvl [8];
  logic [5:0] r_vgein, c_vsid [8];
  logic [63:0] r_hgeie;
  int errors = 0, checks = 0, cycles = 0, seed = 27, kill_acks = 0;

  clic_tb_clk u_clk (.clk_o(clk), .rst_no(rst_n));

  clic_subsys_top dut0 (
    .clk_i(clk), .rst_ni(rst_n), .irq_src_i(src),
    .src_cfg_we_i(cfg_we), .src_cfg_id_i(cfg_id), .src_cfg_en_i(cfg_en),
    .src_cfg_level_i(cfg_level), .src_cfg_priv_i(cfg_priv), .src_cfg_v_i(cfg_v),
    .src_cfg_vsid_i(cfg_vsid), .csr_we_i(csr_we), .csr_addr_i(csr_addr),
    .csr_wdata_i(csr_wdata), .mret_i(mret), .trap_o(trap), .trap_cause_o(trap_cause),
    .priv_lvl_o(priv), .v_o(v), .mil_o(mil), .irq_kill_ack_o(kill_ack)
  );

  always @(posedge clk) begin
    cycles++;
    if (cycles >= 3000) begin  // Roughly six times the test length
      $display("Timeout: simulation did not finish within 3000 cycles");
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // Kill acks seen on the top-level port
  always @(negedge clk) begin
    if (rst_n && kill_ack) kill_acks++;
  end

  // ----------------------------------------
  // Acceptance per privilege mode
  // ----------------------------------------
  function automatic bit want_trap(input int id, output bit vexp);
    logic [7:0] lv, meff, seff, vseff;
    lv = c_lvl[id];
    meff = (r_mth > r_mil) ? r_mth : r_mil;
    seff = (r_sth > r_sil) ? r_sth : r_sil;
    vseff = (r_vsth > r_vsil) ? r_vsth : r_vsil;
    vexp = 1'b0;
    want_trap = 1'b0;
    if (r_priv == PRIV_LVL_M) begin
      want_trap = (c_priv[id] == PRIV_LVL_M) && (lv > meff);
    end else if (r_priv == PRIV_LVL_S) begin
      if (c_priv[id] == PRIV_LVL_M) want_trap = 1'b1;
      else if (c_priv[id] == PRIV_LVL_S) begin
        if (!r_v) want_trap = !c_v[id] && r_sie && (lv > seff);
        else if (!c_v[id]) want_trap = lv > seff;          // Host S irq
        else if (c_vsid[id] == r_vgein) begin              // Running guest
          want_trap = r_vsie && (lv > vseff);
          vexp = 1'b1;
        end else want_trap = r_sgeie && r_hgeie[c_vsid[id]];
      end
    end else begin
      want_trap = 1'b1;  // U mode takes all
      vexp = c_v[id];
    end
  endfunction

  task automatic cfg_src(input int id, input logic [7:0] lvl, input priv_lvl_e p,
                         input logic vv, input logic [5:0] vsid);
    @(posedge clk);
    cfg_we <= 1'b1;
    cfg_id <= 3'(id);
    cfg_en <= 1'b1;
    cfg_level <= lvl;
    cfg_priv <= p;
    cfg_v <= vv;
    cfg_vsid <= vsid;
    @(posedge clk);
    cfg_we <= 1'b0;
    c_lvl[id] = lvl;
    c_priv[id] = p;
    c_v[id] = vv;
    c_vsid[id] = vsid;
  endtask

  task automatic csr_wr(input csr_addr_e a, input logic [31:0] d);
    @(posedge clk);
    csr_we <= 1'b1;
    csr_addr <= a;
    csr_wdata <= d;
    @(posedge clk);
    csr_we <= 1'b0;
    case (a)
      CSR_MINTTHRESH:  r_mth = d[7:0];
      CSR_SINTTHRESH:  r_sth = d[7:0];
      CSR_VSINTTHRESH: r_vsth = d[7:0];
      CSR_IRQ_CTRL: begin
        {r_sgeie, r_vsie, r_sie} = d[2:0];
        r_vgein = d[9:4];
      end
      CSR_HGEIE_LO:    r_hgeie[31:0] = d;
      CSR_HGEIE_HI:    r_hgeie[63:32] = d;
      default: begin
        r_priv = priv_lvl_e'(d[1:0]);
        r_v = d[2];
      end
    endcase
  endtask

  task automatic do_mret();
    @(posedge clk);
    mret <= 1'b1;
    @(posedge clk);
    mret <= 1'b0;
    if (r_priv == PRIV_LVL_M) r_mil = s_lvl;
    else if (r_v) r_vsil = s_lvl;
    else r_sil = s_lvl;
    r_priv = s_priv;
    r_v = s_v;
    @(negedge clk);
    checks++;
    assert (priv == r_priv && v == r_v && mil == r_mil) else begin
      $display("FAILED at %0t: mret gave priv %0d mil %0d", $time, priv, mil);
      errors++;
    end
  endtask

  // Raise lines, expect source id to trap or not, then drop them
  task automatic fire(input logic [7:0] mask, input int id, input bit do_ret);
    bit want, vexp, got;
    logic [31:0] cause;
    want = want_trap(id, vexp);
    got = 1'b0;
    cause = {1'b1, 7'b0, c_lvl[id], 13'b0, 3'(id)};
    @(posedge clk);
    src <= mask;
    for (int n = 0; n < 8 && !got; n++) begin
      @(negedge clk);
      got = trap;
    end
    checks++;
    assert (got == want) else begin
      $display("FAILED at %0t: source %0d trap %0b expected %0b", $time, id, got, want);
      errors++;
    end
    if (got && want) begin
      s_priv = r_priv;
      s_v = r_v;
      if (c_priv[id] == PRIV_LVL_M) begin
        s_lvl = r_mil;
        r_mil = c_lvl[id];
      end else if (vexp) begin
        s_lvl = r_vsil;
        r_vsil = c_lvl[id];
      end else begin
        s_lvl = r_sil;
        r_sil = c_lvl[id];
      end
      r_priv = c_priv[id];
      r_v = vexp;
      checks++;
      assert (trap_cause == cause && priv == r_priv && v == r_v && mil == r_mil) else begin
        $display("FAILED at %0t: cause %h priv %0d v %0b mil %0d", $time,
                 trap_cause, priv, v, mil);
        errors++;
      end
    end
    @(posedge clk);
    src <= '0;
    repeat (6) @(posedge clk);
    if (got && do_ret) do_mret();
  endtask

  initial begin
    logic [7:0] mask;
    int best;
    int acks_before;
    src = '0;
    cfg_we = 0;
    cfg_id = 0;
    cfg_en = 0;
    cfg_level = 0;
    cfg_priv = PRIV_LVL_M;
    cfg_v = 0;
    cfg_vsid = 0;
    csr_we = 0;
    csr_addr = CSR_MINTTHRESH;
    csr_wdata = 0;
    mret = 0;
    r_priv = PRIV_LVL_M;
    r_v = 0;
    {r_sie, r_vsie, r_sgeie} = '0;
    {r_mth, r_sth, r_vsth, r_mil, r_sil, r_vsil} = '0;
    r_vgein = '0;
    r_hgeie = '0;
    @(posedge rst_n);

    // M threshold and return
    csr_wr(CSR_MINTTHRESH, 32'd40);
    cfg_src(3, 8'd40, PRIV_LVL_M, 0, 0);
    fire(8'h08, 3, 1);
    cfg_src(3, 8'd41, PRIV_LVL_M, 0, 0);
    fire(8'h08, 3, 0);
    fire(8'h08, 3, 0);  // Masked by mil
    do_mret();
    fire(8'h08, 3, 1);  // Equal level taken again

    // Arbitration with random levels, ids 1 and 6 tied
    csr_wr(CSR_MINTTHRESH, 32'd0);
    repeat (3) begin
      for (int i = 0; i < 8; i++) cfg_src(i, 8'(($random(seed) & 8'h7f) + 1), PRIV_LVL_M, 0, 0);
      cfg_src(6, c_lvl[1], PRIV_LVL_M, 0, 0);
      mask = 8'($random(seed)) | 8'h42;
      best = -1;
      for (int i = 0; i < 8; i++)
        if (mask[i] && (best < 0 || c_lvl[i] > c_lvl[best])) best = i;
      fire(mask, best, 1);
    end

    // S mode gating
    csr_wr(CSR_PRIV, 32'd1);
    cfg_src(2, 8'd30, PRIV_LVL_S, 0, 0);
    fire(8'h04, 2, 1);
    csr_wr(CSR_IRQ_CTRL, 32'h1);
    csr_wr(CSR_SINTTHRESH, 32'd30);
    fire(8'h04, 2, 1);
    csr_wr(CSR_SINTTHRESH, 32'd10);
    fire(8'h04, 2, 1);
    cfg_src(4, 8'd5, PRIV_LVL_M, 0, 0);
    fire(8'h10, 4, 1);
    cfg_src(5, 8'd20, PRIV_LVL_S, 1, 6'd3);
    fire(8'h20, 5, 1);

    // VS routing, then U mode
    csr_wr(CSR_PRIV, 32'd5);
    csr_wr(CSR_IRQ_CTRL, 32'h32);        // vsie, vgein 3
    csr_wr(CSR_VSINTTHRESH, 32'd10);
    fire(8'h20, 5, 1);
    cfg_src(6, 8'd8, PRIV_LVL_S, 1, 6'd40);
    fire(8'h40, 6, 1);
    csr_wr(CSR_IRQ_CTRL, 32'h36);        // Add sgeie
    csr_wr(CSR_HGEIE_HI, 32'h100);       // Guest 40
    fire(8'h40, 6, 1);
    csr_wr(CSR_PRIV, 32'd0);
    fire(8'h20, 5, 1);

    // Kill by a better source while one is presented
    csr_wr(CSR_PRIV, 32'd3);
    csr_wr(CSR_MINTTHRESH, 32'd20);
    cfg_src(0, 8'd10, PRIV_LVL_M, 0, 0);
    cfg_src(1, 8'd50, PRIV_LVL_M, 0, 0);
    acks_before = kill_acks;
    @(posedge clk);
    src <= 8'h01;
    repeat (5) @(posedge clk);
    checks++;
    assert (kill_acks == acks_before) else begin
      $display("FAILED at %0t: kill ack with no better source", $time);
      errors++;
    end
    fire(8'h03, 1, 1);
    checks++;
    assert (kill_acks > acks_before) else begin
      $display("FAILED at %0t: no kill ack for the outranked source", $time);
      errors++;
    end

    repeat (4) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: clic_tb_sva.sv
// ----------------------------------------
// Kill protocol assertions, bound to the
// hart controller and the source arbiter
// ----------------------------------------

`timescale 1ns/1ps

module clic_tb_sva (
  input logic clk_i,
  input logic rst_ni,
  input logic req_i,       // Controller request
  input logic ack_i,       // Kill acknowledge
  input logic kill_req_i,
  input logic valid_i,     // Presented irq
  input logic cand_i       // Some source still pending
);
  // No ack while a raised request is still in flight
  ack_no_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |=> !ack_i)
    else $error("kill ack raised for an irq in flight");

  // Request is held until acknowledged
  kill_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    kill_req_i && !ack_i |=> kill_req_i)
    else $error("kill request dropped without acknowledge");

  // Presentation withdrawn right after ack
  valid_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_i |=> !valid_i)
    else $error("irq still valid after kill acknowledge");

  // Pending sources come back after a kill
  represent: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_i && cand_i |=> ##1 valid_i)
    else $error("pending source not presented again after kill");

endmodule

bind clic_hart_ctrl clic_tb_sva u_sva_ctrl (
  .clk_i, .rst_ni,
  .req_i      (irq_req_o),
  .ack_i      (irq_kill_ack_o),
  .kill_req_i (irq_kill_req_i),
  .valid_i    (irq_valid_i),
  .cand_i     (1'b0)
);

bind clic_src_arbiter clic_tb_sva u_sva_arb (
  .clk_i, .rst_ni,
  .req_i      (1'b0),
  .ack_i      (irq_kill_ack_i),
  .kill_req_i (irq_kill_req_o),
  .valid_i    (irq_valid_o),
  .cand_i     (|cand)
);

// File: clic_tb_clk.sv
// ----------------------------------------
// Testbench clock and reset generator
// ----------------------------------------

`timescale 1ns/1ps

module clic_tb_clk (
  output logic clk_o,
  output logic rst_no
);
  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;                       // Held for two cycles
    repeat (2) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  always #50 clk_o = ~clk_o;             // 100 ns period

endmodule

// File: clic_subsys_top.sv
// ----------------------------------------
// CLIC subsystem top: arbiter, hart-side
// controller and trap/CSR stub
// ----------------------------------------

`timescale 1ns/1ps

module clic_subsys_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [clic_pkg::NumSrc-1:0]     irq_src_i,
  input  logic                            src_cfg_we_i,
  input  logic [clic_pkg::IdWidth-1:0]    src_cfg_id_i,
  input  logic                            src_cfg_en_i,
  input  logic [7:0]                      src_cfg_level_i,
  input  clic_pkg::priv_lvl_e             src_cfg_priv_i,
  input  logic                            src_cfg_v_i,
  input  logic [clic_pkg::VsidWidth-1:0]  src_cfg_vsid_i,
  input  logic                            csr_we_i,
  input  clic_pkg::csr_addr_e             csr_addr_i,
  input  logic [clic_pkg::Xlen-1:0]       csr_wdata_i,
  input  logic                            mret_i,
  output logic                            trap_o,
  output logic [clic_pkg::Xlen-1:0]       trap_cause_o,
  output clic_pkg::priv_lvl_e             priv_lvl_o,
  output logic                            v_o,
  output logic [7:0]                      mil_o,
  output logic                            irq_kill_ack_o
);
  import clic_pkg::*;

  // ----------------------------------------
  // Arbiter to controller
  // ----------------------------------------
  logic                 irq_valid, irq_v, irq_kill_req, irq_ready;
  logic [IdWidth-1:0]   irq_id;
  logic [7:0]           irq_level;
  priv_lvl_e            irq_priv;
  logic [VsidWidth-1:0] irq_vsid;

  // Controller to trap stub
  logic                 irq_req, irq_v_out;
  priv_lvl_e            irq_priv_out;
  logic [Xlen-1:0]      irq_cause;

  // Trap stub state back to controller
  logic                 sie, vsie, sgeie;
  logic [VsidWidth-1:0] vgein;
  logic [NumVs-1:0]     hgeie;
  logic [7:0]           mintthresh, sintthresh, vsintthresh, sil, vsil;

  clic_src_arbiter u_arb (
    .clk_i, .rst_ni, .irq_src_i,
    .src_cfg_we_i, .src_cfg_id_i, .src_cfg_en_i, .src_cfg_level_i,
    .src_cfg_priv_i, .src_cfg_v_i, .src_cfg_vsid_i,
    .irq_ready_i    (irq_ready),
    .irq_kill_ack_i (irq_kill_ack_o),
    .irq_valid_o    (irq_valid),
    .irq_id_o       (irq_id),
    .irq_level_o    (irq_level),
    .irq_priv_o     (irq_priv),
    .irq_v_o        (irq_v),
    .irq_vsid_o     (irq_vsid),
    .irq_kill_req_o (irq_kill_req)
  );

  clic_hart_ctrl u_ctrl (
    .clk_i, .rst_ni,
    .priv_lvl_i (priv_lvl_o), .v_i (v_o),
    .sie_i (sie), .vsie_i (vsie), .sgeie_i (sgeie), .vgein_i (vgein), .hgeie_i (hgeie),
    .mintthresh_i (mintthresh), .sintthresh_i (sintthresh), .vsintthresh_i (vsintthresh),
    .mil_i (mil_o), .sil_i (sil), .vsil_i (vsil),
    .irq_valid_i (irq_valid), .irq_id_i (irq_id), .irq_level_i (irq_level),
    .irq_priv_i (irq_priv), .irq_v_i (irq_v), .irq_vsid_i (irq_vsid),
    .irq_ready_i (irq_ready), .irq_kill_req_i (irq_kill_req),
    .irq_kill_ack_o,
    .irq_req_o (irq_req), .irq_priv_o (irq_priv_out), .irq_v_o (irq_v_out),
    .irq_cause_o (irq_cause)
  );

  clic_trap_csr u_csr (
    .clk_i, .rst_ni, .csr_we_i, .csr_addr_i, .csr_wdata_i, .mret_i,
    .irq_req_i (irq_req), .irq_priv_i (irq_priv_out), .irq_v_i (irq_v_out),
    .irq_cause_i (irq_cause),
    .irq_ready_o (irq_ready), .trap_o, .trap_cause_o, .priv_lvl_o, .v_o,
    .sie_o (sie), .vsie_o (vsie), .sgeie_o (sgeie), .vgein_o (vgein), .hgeie_o (hgeie),
    .mintthresh_o (mintthresh), .sintthresh_o (sintthresh), .vsintthresh_o (vsintthresh),
    .mil_o, .sil_o (sil), .vsil_o (vsil)
  );

endmodule

// File: clic_trap_csr.sv
// ----------------------------------------
// Trap and CSR stub: privilege, thresholds,
// status levels, enables, trap entry, mret
// ----------------------------------------

`timescale 1ns/1ps

module clic_trap_csr (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            csr_we_i,
  input  clic_pkg::csr_addr_e             csr_addr_i,
  input  logic [clic_pkg::Xlen-1:0]       csr_wdata_i,
  input  logic                            mret_i,        // One-deep return
  input  logic                            irq_req_i,
  input  clic_pkg::priv_lvl_e             irq_priv_i,
  input  logic                            irq_v_i,
  input  logic [clic_pkg::Xlen-1:0]       irq_cause_i,
  output logic                            irq_ready_o,
  output logic                            trap_o,
  output logic [clic_pkg::Xlen-1:0]       trap_cause_o,
  output clic_pkg::priv_lvl_e             priv_lvl_o,
  output logic                            v_o,
  output logic                            sie_o,
  output logic                            vsie_o,
  output logic                            sgeie_o,
  output logic [clic_pkg::VsidWidth-1:0]  vgein_o,
  output logic [clic_pkg::NumVs-1:0]      hgeie_o,
  output logic [7:0]                      mintthresh_o,
  output logic [7:0]                      sintthresh_o,
  output logic [7:0]                      vsintthresh_o,
  output logic [7:0]                      mil_o,
  output logic [7:0]                      sil_o,
  output logic [7:0]                      vsil_o
);
  import clic_pkg::*;

  logic       take_q, accept;
  logic [7:0] irq_level;
  priv_lvl_e  ret_priv_q;  // Return slot
  logic       ret_v_q;
  logic [7:0] ret_lvl_q;

  assign accept    = irq_req_i & ~take_q;  // Busy while ready pulses
  assign irq_level = irq_cause_i[CauseLevelLsb +: 8];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      take_q <= 1'b0;
      priv_lvl_o <= PRIV_LVL_M;
      v_o <= 1'b0;
      {sie_o, vsie_o, sgeie_o} <= '0;
      vgein_o <= '0;
      hgeie_o <= '0;
      {mintthresh_o, sintthresh_o, vsintthresh_o} <= '0;
      {mil_o, sil_o, vsil_o} <= '0;
      ret_priv_q <= PRIV_LVL_M;
      ret_v_q <= 1'b0;
      ret_lvl_q <= '0;
    end else begin
      take_q <= accept;
      // ----------------------------------------
      // CSR writes, lowest priority
      // ----------------------------------------
      if (csr_we_i) begin
        case (csr_addr_i)
          CSR_MINTTHRESH:  mintthresh_o  <= csr_wdata_i[7:0];
          CSR_SINTTHRESH:  sintthresh_o  <= csr_wdata_i[7:0];
          CSR_VSINTTHRESH: vsintthresh_o <= csr_wdata_i[7:0];
          CSR_IRQ_CTRL: begin
            {sgeie_o, vsie_o, sie_o} <= csr_wdata_i[2:0];
            vgein_o <= csr_wdata_i[9:4];
          end
          CSR_HGEIE_LO:    hgeie_o[31:0]  <= csr_wdata_i;
          CSR_HGEIE_HI:    hgeie_o[63:32] <= csr_wdata_i;
          CSR_PRIV: begin
            priv_lvl_o <= priv_lvl_e'(csr_wdata_i[1:0]);
            v_o        <= csr_wdata_i[2];
          end
          default: ;
        endcase
      end
      if (mret_i) begin  // Level restored for the mode being left
        priv_lvl_o <= ret_priv_q;
        v_o        <= ret_v_q;
        if (priv_lvl_o == PRIV_LVL_M) mil_o <= ret_lvl_q;
        else if (v_o) vsil_o <= ret_lvl_q;
        else sil_o <= ret_lvl_q;
      end
      // Trap entry wins over everything else
      if (accept) begin
        ret_priv_q <= priv_lvl_o;
        ret_v_q    <= v_o;
        priv_lvl_o <= irq_priv_i;
        v_o        <= irq_v_i;
        if (irq_priv_i == PRIV_LVL_M) begin
          ret_lvl_q <= mil_o;
          mil_o     <= irq_level;
        end else if (irq_v_i) begin
          ret_lvl_q <= vsil_o;
          vsil_o    <= irq_level;
        end else begin
          ret_lvl_q <= sil_o;
          sil_o     <= irq_level;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) trap_cause_o <= irq_cause_i;
  end

  assign irq_ready_o = take_q;  // Ack to arbiter and controller
  assign trap_o      = take_q;

endmodule

// File: clic_hart_ctrl.sv
// ----------------------------------------
// Hart-side CLIC controller: acceptance check,
// cause packing, in-flight and kill tracking
// ----------------------------------------

`timescale 1ns/1ps

module clic_hart_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Hart state
  input  clic_pkg::priv_lvl_e             priv_lvl_i,
  input  logic                            v_i,           // Virtualization bit
  input  logic                            sie_i,
  input  logic                            vsie_i,
  input  logic                            sgeie_i,
  input  logic [clic_pkg::VsidWidth-1:0]  vgein_i,       // Running guest
  input  logic [clic_pkg::NumVs-1:0]      hgeie_i,
  input  logic [7:0]                      mintthresh_i,
  input  logic [7:0]                      sintthresh_i,
  input  logic [7:0]                      vsintthresh_i,
  input  logic [7:0]                      mil_i,
  input  logic [7:0]                      sil_i,
  input  logic [7:0]                      vsil_i,
  // From arbiter
  input  logic                            irq_valid_i,
  input  logic [clic_pkg::IdWidth-1:0]    irq_id_i,
  input  logic [7:0]                      irq_level_i,
  input  clic_pkg::priv_lvl_e             irq_priv_i,
  input  logic                            irq_v_i,
  input  logic [clic_pkg::VsidWidth-1:0]  irq_vsid_i,
  input  logic                            irq_ready_i,
  input  logic                            irq_kill_req_i,
  output logic                            irq_kill_ack_o,
  // To trap stub
  output logic                            irq_req_o,
  output clic_pkg::priv_lvl_e             irq_priv_o,
  output logic                            irq_v_o,
  output logic [clic_pkg::Xlen-1:0]       irq_cause_o
);
  import clic_pkg::*;

  logic [7:0] max_mthresh, max_sthresh, max_vsthresh;
  logic       inflight_d, inflight_q;

  // ----------------------------------------
  // Effective thresholds and acceptance
  // ----------------------------------------
  assign max_mthresh  = (mintthresh_i > mil_i) ? mintthresh_i : mil_i;
  assign max_sthresh  = (sintthresh_i > sil_i) ? sintthresh_i : sil_i;
  assign max_vsthresh = (vsintthresh_i > vsil_i) ? vsintthresh_i : vsil_i;

  always_comb begin
    irq_priv_o = irq_priv_i;
    irq_v_o    = 1'b0;
    irq_req_o  = 1'b0;
    case (priv_lvl_i)
      PRIV_LVL_M: begin
        if (irq_priv_i == PRIV_LVL_M) irq_req_o = irq_valid_i && (irq_level_i > max_mthresh);
      end
      PRIV_LVL_S: begin
        if (irq_priv_i == PRIV_LVL_M) begin
          irq_req_o = irq_valid_i;  // M always preempts S
        end else if (irq_priv_i == PRIV_LVL_S) begin
          if (v_i && irq_v_i) begin
            if (irq_vsid_i == vgein_i) begin  // Own guest
              irq_req_o = irq_valid_i && vsie_i && (irq_level_i > max_vsthresh);
              irq_v_o   = 1'b1;
            end else begin  // Other guest, trap to HS
              irq_req_o = irq_valid_i && sgeie_i && hgeie_i[irq_vsid_i];
            end
          end else if (v_i) begin
            irq_req_o = irq_valid_i && (irq_level_i > max_sthresh);  // Host S, sie implied
          end else if (!irq_v_i) begin
            irq_req_o = irq_valid_i && sie_i && (irq_level_i > max_sthresh);
          end
          // Virtual irq in HS mode is dropped
        end
      end
      PRIV_LVL_U: begin
        irq_req_o = irq_valid_i;
        irq_v_o   = irq_v_i;
      end
      default: ;
    endcase
  end

  // ----------------------------------------
  // Cause word
  // ----------------------------------------
  always_comb begin
    irq_cause_o                             = '0;
    irq_cause_o[CauseIrqBit]                = 1'b1;
    irq_cause_o[CauseLevelLsb +: 8]         = irq_level_i;
    irq_cause_o[IdWidth-1:0]                = irq_id_i;
  end

  // ----------------------------------------
  // In-flight and kill acknowledge
  // ----------------------------------------
  // No ack while an irq is raised or still unanswered
  assign irq_kill_ack_o = irq_kill_req_i & ~inflight_q & ~irq_req_o;
  assign inflight_d     = inflight_q ? ~(irq_ready_i | irq_kill_ack_o) : irq_req_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
    end else begin
      inflight_q <= inflight_d;
    end
  end

endmodule

// File: clic_src_arbiter.sv
// ----------------------------------------
// CLIC source arbiter: config table, pending
// samples, highest-level selection, kill req
// ----------------------------------------

`timescale 1ns/1ps

module clic_src_arbiter (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [clic_pkg::NumSrc-1:0]     irq_src_i,        // Level pending lines
  // Config write port
  input  logic                            src_cfg_we_i,
  input  logic [clic_pkg::IdWidth-1:0]    src_cfg_id_i,
  input  logic                            src_cfg_en_i,
  input  logic [7:0]                      src_cfg_level_i,
  input  clic_pkg::priv_lvl_e             src_cfg_priv_i,
  input  logic                            src_cfg_v_i,
  input  logic [clic_pkg::VsidWidth-1:0]  src_cfg_vsid_i,
  // Hart side
  input  logic                            irq_ready_i,      // Presented irq taken
  input  logic                            irq_kill_ack_i,
  output logic                            irq_valid_o,
  output logic [clic_pkg::IdWidth-1:0]    irq_id_o,
  output logic [7:0]                      irq_level_o,
  output clic_pkg::priv_lvl_e             irq_priv_o,
  output logic                            irq_v_o,
  output logic [clic_pkg::VsidWidth-1:0]  irq_vsid_o,
  output logic                            irq_kill_req_o
);
  import clic_pkg::*;

  // Per-source configuration
  logic [NumSrc-1:0] cfg_en_q;
  logic [7:0]        cfg_level_q [NumSrc];
  priv_lvl_e         cfg_priv_q  [NumSrc];
  logic              cfg_v_q     [NumSrc];
  logic [VsidWidth-1:0] cfg_vsid_q [NumSrc];

  logic [NumSrc-1:0] pend_q, cand, clr_mask;
  logic              best_valid;
  logic [IdWidth-1:0] best_id;
  logic [7:0]        best_level;
  logic              valid_q, kill_q, lost, better;
  logic [IdWidth-1:0] id_q;

  always_ff @(posedge clk_i) begin
    if (src_cfg_we_i) begin  // Payload fields, no reset
      cfg_level_q[src_cfg_id_i] <= src_cfg_level_i;
      cfg_priv_q[src_cfg_id_i]  <= src_cfg_priv_i;
      cfg_v_q[src_cfg_id_i]     <= src_cfg_v_i;
      cfg_vsid_q[src_cfg_id_i]  <= src_cfg_vsid_i;
    end
  end

  // ----------------------------------------
  // Pending and candidate selection
  // ----------------------------------------
  assign clr_mask = {{(NumSrc-1){1'b0}}, irq_ready_i} << id_q;  // Served source
  assign cand     = pend_q & cfg_en_q;

  always_comb begin
    best_valid = 1'b0;
    best_id    = '0;
    best_level = '0;
    for (int i = 0; i < NumSrc; i++) begin
      // Strict compare, lower id keeps ties
      if (cand[i] && (!best_valid || cfg_level_q[i] > best_level)) begin
        best_valid = 1'b1;
        best_id    = IdWidth'(i);
        best_level = cfg_level_q[i];
      end
    end
  end

  // Kill triggers while presenting
  assign lost   = ~cand[id_q];
  assign better = best_valid & (best_id != id_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_en_q <= '0;
      pend_q   <= '0;
      valid_q  <= 1'b0;
      kill_q   <= 1'b0;
      id_q     <= '0;
    end else begin
      if (src_cfg_we_i) cfg_en_q[src_cfg_id_i] <= src_cfg_en_i;
      pend_q <= irq_src_i & ~clr_mask;
      if (irq_ready_i || irq_kill_ack_i) begin
        valid_q <= 1'b0;  // Served or withdrawn
        kill_q  <= 1'b0;
      end else if (valid_q) begin
        if (lost || better) kill_q <= 1'b1;  // Sticky until ack
      end else if (best_valid) begin
        valid_q <= 1'b1;
        id_q    <= best_id;
      end
    end
  end

  // Presentation fields follow the latched id
  assign irq_valid_o    = valid_q;
  assign irq_id_o       = id_q;
  assign irq_level_o    = cfg_level_q[id_q];
  assign irq_priv_o     = cfg_priv_q[id_q];
  assign irq_v_o        = cfg_v_q[id_q];
  assign irq_vsid_o     = cfg_vsid_q[id_q];
  assign irq_kill_req_o = kill_q;

endmodule

// File: clic_pkg.sv
// ----------------------------------------
// Shared CLIC definitions: widths, privilege
// and CSR address enums, cause word layout
// ----------------------------------------

package clic_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int unsigned NumSrc    = 8;    // Interrupt sources
  localparam int unsigned IdWidth   = 3;    // Source id bits
  localparam int unsigned VsidWidth = 6;    // VS-id bits
  localparam int unsigned NumVs     = 64;   // Guest external enables (hgeie)
  localparam int unsigned Xlen      = 32;   // Cause and CSR data width

  // Cause word layout
  localparam int unsigned CauseIrqBit   = Xlen - 1;  // Interrupt flag
  localparam int unsigned CauseLevelLsb = 16;        // Level field at 23..16

  // ----------------------------------------
  // Privilege levels, RISC-V encoding
  // ----------------------------------------
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Writable interrupt state of the hart
  typedef enum logic [2:0] {
    CSR_MINTTHRESH  = 3'd0,  // M threshold, bits 7..0
    CSR_SINTTHRESH  = 3'd1,  // S threshold
    CSR_VSINTTHRESH = 3'd2,  // VS threshold
    CSR_IRQ_CTRL    = 3'd3,  // sie, vsie, sgeie in 2..0, vgein in 9..4
    CSR_HGEIE_LO    = 3'd4,  // hgeie 31..0
    CSR_HGEIE_HI    = 3'd5,  // hgeie 63..32
    CSR_PRIV        = 3'd6   // priv in 1..0, v in 2
  } csr_addr_e;

endpackage
